// File: logic/sdram_defines.svh
// sdram timing, geometry and fixed bus words, included by any file that needs these values
`ifndef SDRAM_DEFINES_SVH
`define SDRAM_DEFINES_SVH

// power-up settling wait in cycles
// kept short for simulation, a real part wants about 100 us
`define SDRAM_INIT_WAIT 20

// auto-refresh period in cycles
`define SDRAM_REFRESH_INTERVAL 150

// core timing in cycles
`define SDRAM_TRCD 2
`define SDRAM_TRP 2
`define SDRAM_TRFC 6
`define SDRAM_TWR 2

// read latency from command to first beat
`define SDRAM_CAS_LAT 2

// fixed wishbone words
`define SDRAM_STATUS_ADDR 32'h00FFFFFF
`define SDRAM_ERR_WORD 32'hFFFFFFFF

// mode register
// burst length 2 (a2:a0 = 001), sequential (a3 = 0), cas latency 2 (a6:a4 = 010)
`define SDRAM_MODE_WORD 13'h021

`endif

// File: logic/sdram_pkg.sv
// shared request, status, command and response-select types for the wishbone sdram slave
package sdram_pkg;

	`include "sdram_defines.svh"

	// word address split, bank on top
	typedef struct packed {
		logic [1:0]  bank;
		logic [12:0] row;
		logic [8:0]  col;
	} addr_map_t;

	// one memory access from the bus front end
	typedef struct packed {
		logic        write;
		addr_map_t   addr;
		logic [31:0] data;
	} mem_req_t;

	// bit 0 ready, bit 1 ack, bit 2 busy
	typedef struct packed {
		logic busy;
		logic ack;
		logic ready;
	} ctrl_status_t;

	// registered sdram pin bundle
	typedef struct packed {
		logic        cs_n;
		logic        ras_n;
		logic        cas_n;
		logic        we_n;
		logic [1:0]  ba;
		logic [12:0] addr;
		logic [1:0]  dqm;
		logic        cke;
	} sdram_cmd_t;

	typedef enum logic [1:0] {
		SEL_NONE,
		SEL_STATUS,
		SEL_ERROR,
		SEL_MEMORY
	} rsp_sel_t;

	// {cs_n, ras_n, cas_n, we_n}
	localparam logic [3:0] CMD_NOP   = 4'b0111;
	localparam logic [3:0] CMD_ACT   = 4'b0011;
	localparam logic [3:0] CMD_READ  = 4'b0101;
	localparam logic [3:0] CMD_WRITE = 4'b0100;
	localparam logic [3:0] CMD_PRE   = 4'b0010;
	localparam logic [3:0] CMD_REF   = 4'b0001;
	localparam logic [3:0] CMD_MRS   = 4'b0000;

	// pins while in reset, clock disabled and data masked
	localparam sdram_cmd_t CMD_RESET = '{cs_n: 1'b1, ras_n: 1'b1, cas_n: 1'b1,
		we_n: 1'b1, ba: 2'b00, addr: 13'h0000, dqm: 2'b11, cke: 1'b0};

	function automatic logic is_status_addr(input logic [31:0] adr);
		return adr == `SDRAM_STATUS_ADDR;
	endfunction

	// device column is two halfwords per word, a10 set for auto-precharge
	function automatic logic [12:0] dev_col_addr(input logic [8:0] col);
		return {2'b00, 1'b1, col, 1'b0};
	endfunction

endpackage

// File: logic/wb_request_decode.sv
// wishbone front end, classifies each access once and hands memory requests to the sequencer
module wb_request_decode import sdram_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        wb_stb_i,
	input  logic        wb_cyc_i,
	input  logic        wb_we_i,
	input  logic [31:0] wb_adr_i,
	input  logic [31:0] wb_dat_i,
	input  logic        ready_i,
	input  logic        ack_i,
	output mem_req_t    req_o,
	output logic        req_vld_o,
	output rsp_sel_t    sel_o
);

	logic live;
	logic pending;
	logic accept;
	logic status_rd;

	// bus cycle in progress
	assign live = wb_stb_i & wb_cyc_i;

	// one sample per strobe
	// ack still high means the master has not dropped the strobe yet
	assign accept = live & ~pending & ~ack_i;

	// only reads see the status word, a write there goes to memory like any other
	assign status_rd = ~wb_we_i & is_status_addr(wb_adr_i);

	always_ff @(posedge clk) begin
		req_vld_o <= 1'b0;
		if (rst) begin
			pending <= 1'b0;
			sel_o <= SEL_NONE;
		end else begin
			// status and error selects last one cycle
			if (sel_o != SEL_MEMORY)
				sel_o <= SEL_NONE;

			if (ack_i) begin
				// response is out, access is finished
				pending <= 1'b0;
				sel_o <= SEL_NONE;
			end else if (accept) begin
				pending <= 1'b1;
				if (status_rd) begin
					sel_o <= SEL_STATUS;
				end else if (!ready_i) begin
					// init still running
					sel_o <= SEL_ERROR;
				end else begin
					// memory select held until ack
					sel_o <= SEL_MEMORY;
					req_vld_o <= 1'b1;
				end
			end
		end
	end

	// request payload
	// loaded on every accepted access, only read while req_vld_o is high
	always_ff @(posedge clk) begin
		if (accept) begin
			req_o.write <= wb_we_i;
			req_o.addr <= wb_adr_i[23:0];
			req_o.data <= wb_dat_i;
		end
	end

endmodule

// File: logic/sdram_cmd_sequencer.sv
// sdram command FSM, runs power-up init and refresh and turns one-word requests into bursts of two
module sdram_cmd_sequencer import sdram_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  mem_req_t     req_i,
	input  logic         req_vld_i,
	output logic         done_o,
	output logic [31:0]  rdata_o,
	output ctrl_status_t status_o,
	output sdram_cmd_t   cmd_o,
	output logic [15:0]  dq_o,
	output logic         dq_oe_o,
	input  logic [15:0]  dq_i
);

	`include "sdram_defines.svh"

	typedef enum logic [3:0] {
		S_INIT_WAIT,
		S_INIT_PRE,
		S_INIT_REF1,
		S_INIT_REF2,
		S_INIT_MRS,
		S_IDLE,
		S_REFRESH,
		S_ACT,
		S_WR_BEAT,
		S_WR_RECOV,
		S_RD_WAIT,
		S_RD_BEAT
	} state_t;

	state_t      state;
	logic [15:0] wait_cnt;
	logic [15:0] ref_cnt;
	logic        ref_due;
	logic        ref_issue;
	logic        init_done;
	logic        req_pend;
	mem_req_t    req_q;
	logic        wait_over;

	assign wait_over = (wait_cnt == 16'd0);

	// refresh beats a waiting request
	assign ref_issue = (state == S_IDLE) & ref_due;

	assign status_o.ready = init_done;
	assign status_o.ack = done_o;
	assign status_o.busy = (state != S_IDLE);

	// request may land while a refresh runs, so keep it
	always_ff @(posedge clk) begin
		if (req_vld_i)
			req_q <= req_i;
	end

	// refresh interval timer
	always_ff @(posedge clk) begin
		if (rst) begin
			ref_cnt <= 16'(`SDRAM_REFRESH_INTERVAL - 1);
			ref_due <= 1'b0;
		end else begin
			if (ref_issue)
				ref_due <= 1'b0;
			if (ref_cnt == 16'd0) begin
				ref_cnt <= 16'(`SDRAM_REFRESH_INTERVAL - 1);
				ref_due <= 1'b1;
			end else begin
				ref_cnt <= ref_cnt - 16'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		done_o <= 1'b0;
		// nop unless a state below issues something
		{cmd_o.cs_n, cmd_o.ras_n, cmd_o.cas_n, cmd_o.we_n} <= CMD_NOP;
		if (!wait_over)
			wait_cnt <= wait_cnt - 16'd1;
		if (req_vld_i)
			req_pend <= 1'b1;

		if (rst) begin
			state <= S_INIT_WAIT;
			wait_cnt <= 16'(`SDRAM_INIT_WAIT - 1);
			cmd_o <= CMD_RESET;
			dq_oe_o <= 1'b0;
			init_done <= 1'b0;
			req_pend <= 1'b0;
			rdata_o <= 32'h0;
		end else begin
			case (state)
				S_INIT_WAIT: if (wait_over) begin
					// clock on, precharge all banks
					cmd_o.cke <= 1'b1;
					cmd_o.dqm <= 2'b00;
					{cmd_o.cs_n, cmd_o.ras_n, cmd_o.cas_n, cmd_o.we_n} <= CMD_PRE;
					cmd_o.addr <= 13'h0400;
					wait_cnt <= 16'(`SDRAM_TRP - 1);
					state <= S_INIT_PRE;
				end
				S_INIT_PRE: if (wait_over) begin
					{cmd_o.cs_n, cmd_o.ras_n, cmd_o.cas_n, cmd_o.we_n} <= CMD_REF;
					wait_cnt <= 16'(`SDRAM_TRFC - 1);
					state <= S_INIT_REF1;
				end
				S_INIT_REF1: if (wait_over) begin
					{cmd_o.cs_n, cmd_o.ras_n, cmd_o.cas_n, cmd_o.we_n} <= CMD_REF;
					wait_cnt <= 16'(`SDRAM_TRFC - 1);
					state <= S_INIT_REF2;
				end
				S_INIT_REF2: if (wait_over) begin
					// mode register, bank bits zero
					{cmd_o.cs_n, cmd_o.ras_n, cmd_o.cas_n, cmd_o.we_n} <= CMD_MRS;
					cmd_o.ba <= 2'b00;
					cmd_o.addr <= `SDRAM_MODE_WORD;
					wait_cnt <= 16'(`SDRAM_TRP - 1);
					state <= S_INIT_MRS;
				end
				S_INIT_MRS: if (wait_over) begin
					init_done <= 1'b1;
					state <= S_IDLE;
				end
				S_IDLE: begin
					if (ref_due) begin
						{cmd_o.cs_n, cmd_o.ras_n, cmd_o.cas_n, cmd_o.we_n} <= CMD_REF;
						wait_cnt <= 16'(`SDRAM_TRFC - 1);
						state <= S_REFRESH;
					end else if (req_pend) begin
						// open the row
						{cmd_o.cs_n, cmd_o.ras_n, cmd_o.cas_n, cmd_o.we_n} <= CMD_ACT;
						cmd_o.ba <= req_q.addr.bank;
						cmd_o.addr <= req_q.addr.row;
						wait_cnt <= 16'(`SDRAM_TRCD - 1);
						req_pend <= 1'b0;
						state <= S_ACT;
					end
				end
				S_REFRESH: if (wait_over)
					state <= S_IDLE;
				S_ACT: if (wait_over) begin
					cmd_o.addr <= dev_col_addr(req_q.addr.col);
					if (req_q.write) begin
						// first beat goes out with the command
						{cmd_o.cs_n, cmd_o.ras_n, cmd_o.cas_n, cmd_o.we_n} <= CMD_WRITE;
						dq_o <= req_q.data[15:0];
						dq_oe_o <= 1'b1;
						state <= S_WR_BEAT;
					end else begin
						{cmd_o.cs_n, cmd_o.ras_n, cmd_o.cas_n, cmd_o.we_n} <= CMD_READ;
						wait_cnt <= 16'(`SDRAM_CAS_LAT);
						state <= S_RD_WAIT;
					end
				end
				S_WR_BEAT: begin
					dq_o <= req_q.data[31:16];
					// write recovery then auto-precharge
					wait_cnt <= 16'(`SDRAM_TWR + `SDRAM_TRP - 1);
					state <= S_WR_RECOV;
				end
				S_WR_RECOV: begin
					dq_oe_o <= 1'b0;
					if (wait_over) begin
						done_o <= 1'b1;
						state <= S_IDLE;
					end
				end
				S_RD_WAIT: if (wait_over) begin
					// low half first
					rdata_o[15:0] <= dq_i;
					state <= S_RD_BEAT;
				end
				S_RD_BEAT: begin
					rdata_o[31:16] <= dq_i;
					done_o <= 1'b1;
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: logic/wb_response.sv
// wishbone acknowledge and read data, picks status, error word or memory result per access
module wb_response import sdram_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  rsp_sel_t     sel_i,
	input  ctrl_status_t status_i,
	input  logic         done_i,
	input  logic [31:0]  rdata_i,
	input  logic         wb_stb_i,
	output logic         wb_ack_o,
	output logic [31:0]  wb_dat_o
);

	`include "sdram_defines.svh"

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack_o <= 1'b0;
			wb_dat_o <= 32'h0;
		end else begin
			// master saw ack and let go of the strobe
			if (wb_ack_o && !wb_stb_i)
				wb_ack_o <= 1'b0;

			case (sel_i)
				SEL_STATUS: begin
					// flags in the low three bits
					wb_ack_o <= 1'b1;
					wb_dat_o <= {29'h0, status_i};
				end
				SEL_ERROR: begin
					wb_ack_o <= 1'b1;
					wb_dat_o <= `SDRAM_ERR_WORD;
				end
				SEL_MEMORY: begin
					// wait for the sequencer
					// rdata only changes on reads, so a write returns the last read word
					if (done_i) begin
						wb_ack_o <= 1'b1;
						wb_dat_o <= rdata_i;
					end
				end
				default: begin
					// no access in flight
				end
			endcase
		end
	end

endmodule

// File: logic/sdram_wb_slave.sv
// top level of the wishbone sdram slave, connects request decode, command sequencer and response
module sdram_wb_slave import sdram_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        wb_stb_i,
	input  logic        wb_cyc_i,
	input  logic        wb_we_i,
	input  logic [31:0] wb_adr_i,
	input  logic [31:0] wb_dat_i,
	output logic        wb_ack_o,
	output logic [31:0] wb_dat_o,
	output sdram_cmd_t  sdram_cmd_o,
	output logic [15:0] sdram_dq_o,
	output logic        sdram_dq_oe_o,
	input  logic [15:0] sdram_dq_i
);

	mem_req_t     req;
	logic         req_vld;
	rsp_sel_t     sel;
	logic         done;
	logic [31:0]  rdata;
	ctrl_status_t status;

	// front end, ack from the response side closes each access
	wb_request_decode decode_i (
		.clk       (clk),
		.rst       (rst),
		.wb_stb_i  (wb_stb_i),
		.wb_cyc_i  (wb_cyc_i),
		.wb_we_i   (wb_we_i),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.ready_i   (status.ready),
		.ack_i     (wb_ack_o),
		.req_o     (req),
		.req_vld_o (req_vld),
		.sel_o     (sel)
	);

	sdram_cmd_sequencer seq_i (
		.clk       (clk),
		.rst       (rst),
		.req_i     (req),
		.req_vld_i (req_vld),
		.done_o    (done),
		.rdata_o   (rdata),
		.status_o  (status),
		.cmd_o     (sdram_cmd_o),
		.dq_o      (sdram_dq_o),
		.dq_oe_o   (sdram_dq_oe_o),
		.dq_i      (sdram_dq_i)
	);

	wb_response rsp_i (
		.clk      (clk),
		.rst      (rst),
		.sel_i    (sel),
		.status_i (status),
		.done_i   (done),
		.rdata_i  (rdata),
		.wb_stb_i (wb_stb_i),
		.wb_ack_o (wb_ack_o),
		.wb_dat_o (wb_dat_o)
	);

endmodule

// File: testbench/sdram_model.sv
// behavioural sdr sdram for the testbench, cas latency 2 and burst length 2, flags illegal command order
module sdram_model import sdram_pkg::*; (
	input  logic        clk,
	input  sdram_cmd_t  cmd_i,
	input  logic [15:0] dq_i,
	input  logic        dq_oe_i,
	output logic [15:0] dq_o,
	output logic        dq_oe_o,
	output logic        fault_o,
	output int unsigned act_count_o,
	output int unsigned ref_count_o
);

	timeunit 1ns;
	timeprecision 100ps;

	`include "sdram_defines.svh"

	// halfword storage keyed by {bank, row, device column}
	logic [15:0] store [logic [24:0]];
	logic [3:0]  row_open;
	logic [12:0] open_row [4];
	logic        mode_set;
	logic [24:0] wr_key;
	logic        wr_second;
	logic [24:0] rd_key;
	int          rd_wait;
	int          rd_beats;

	initial begin
		row_open = 4'h0;
		mode_set = 1'b0;
		wr_second = 1'b0;
		rd_wait = 0;
		rd_beats = 0;
		dq_o = 16'h0000;
		dq_oe_o = 1'b0;
		fault_o = 1'b0;
		act_count_o = 0;
		ref_count_o = 0;
	end

	// unwritten locations return a pattern of the full key
	function automatic logic [15:0] read_key(input logic [24:0] key);
		if (store.exists(key))
			return store[key];
		return key[15:0] ^ {7'h00, key[24:16]};
	endfunction

	// backdoor view for the testbench
	function automatic logic [15:0] peek(input logic [1:0] bank, input logic [12:0] row,
		input logic [9:0] col);
		return read_key({bank, row, col});
	endfunction

	task automatic report(input string what);
		$display("sdram model error: %s at %0t", what, $time);
		fault_o <= 1'b1;
	endtask

	always @(posedge clk) begin
		logic [24:0] key;
		key = {cmd_i.ba, open_row[cmd_i.ba], cmd_i.addr[9:0]};

		if (dq_oe_o && dq_oe_i)
			report("controller and memory drive the data bus together");

		// second write beat, other column of the pair
		if (wr_second) begin
			if (dq_oe_i !== 1'b1)
				report("second write beat was not driven");
			store[wr_key ^ 25'd1] = dq_i;
			wr_second <= 1'b0;
		end

		// read beats, first one lands cas latency edges after the command
		if (rd_beats > 0) begin
			if (rd_wait > 1) begin
				rd_wait <= rd_wait - 1;
			end else begin
				dq_o <= read_key(rd_key ^ 25'(2 - rd_beats));
				dq_oe_o <= 1'b1;
				rd_beats <= rd_beats - 1;
			end
		end else begin
			dq_oe_o <= 1'b0;
		end

		// commands only count with clock enabled and chip selected
		if (cmd_i.cke === 1'b1 && cmd_i.cs_n === 1'b0) begin
			case ({cmd_i.cs_n, cmd_i.ras_n, cmd_i.cas_n, cmd_i.we_n})
				CMD_ACT: begin
					if (row_open[cmd_i.ba])
						report("activate to a bank with a row already open");
					row_open[cmd_i.ba] = 1'b1;
					open_row[cmd_i.ba] = cmd_i.addr;
					act_count_o <= act_count_o + 1;
				end
				CMD_READ, CMD_WRITE: begin
					if (!mode_set)
						report("access before the mode register was loaded");
					// no byte masking, both halves always transfer
					if (cmd_i.dqm !== 2'b00)
						report("data mask set on a read or write");
					if (!row_open[cmd_i.ba]) begin
						report("read or write to a bank with no open row");
					end else if (cmd_i.we_n) begin
						rd_key <= key;
						rd_wait <= `SDRAM_CAS_LAT - 1;
						rd_beats <= 2;
					end else begin
						if (dq_oe_i !== 1'b1)
							report("first write beat was not driven");
						store[key] = dq_i;
						wr_key <= key;
						wr_second <= 1'b1;
					end
					// a10 closes the bank after the burst
					if (cmd_i.addr[10])
						row_open[cmd_i.ba] = 1'b0;
				end
				CMD_PRE: begin
					if (cmd_i.addr[10])
						row_open = 4'h0;
					else
						row_open[cmd_i.ba] = 1'b0;
				end
				CMD_REF: begin
					if (row_open != 4'h0)
						report("auto-refresh while a row is open");
					ref_count_o <= ref_count_o + 1;
				end
				CMD_MRS: begin
					// burst length 2 and the expected cas latency
					if (cmd_i.addr[2:0] != 3'b001 || cmd_i.addr[6:4] != 3'(`SDRAM_CAS_LAT))
						report("mode register value does not match burst 2 and cas latency");
					mode_set = 1'b1;
				end
				CMD_NOP: begin
				end
				default: report("unknown command on the pins");
			endcase
		end
	end

endmodule

// File: testbench/tb_sdram_wb_slave.sv
// directed testbench for the wishbone sdram slave, runs bus accesses against a behavioural sdram
module tb_sdram_wb_slave import sdram_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	`include "sdram_defines.svh"

	localparam int CLK_HALF = 4;
	localparam int DRIVE_DELAY = 1;
	localparam int RESET_CYCLES = 10;
	// bus wait bound per access
	localparam int ACK_BOUND = 64;
	// init commands after the settling wait, with margin
	localparam int INIT_ALLOW = 64;
	localparam int NUM_WORDS = 32;
	// refresh intervals the read stream must cover
	localparam int REF_SPAN = 3;
	localparam int STREAM_MAX = 100;
	localparam int POLL_MAX = `SDRAM_INIT_WAIT + INIT_ALLOW;
	localparam int NUM_ACCESSES = 3 + POLL_MAX + 2 + 2 * NUM_WORDS + STREAM_MAX + 2;
	localparam int WATCHDOG_CYCLES = NUM_ACCESSES * ACK_BOUND + RESET_CYCLES +
		`SDRAM_INIT_WAIT + INIT_ALLOW + (REF_SPAN + 1) * `SDRAM_REFRESH_INTERVAL;

	logic        clk;
	logic        rst;
	logic        wb_stb;
	logic        wb_cyc;
	logic        wb_we;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic        wb_ack;
	logic [31:0] wb_dat_r;
	sdram_cmd_t  sdram_cmd;
	logic [15:0] ctrl_dq;
	logic        ctrl_oe;
	logic [15:0] mem_dq;
	logic        mem_oe;
	logic [15:0] dq_to_dut;
	logic        mem_fault;
	int unsigned act_count;
	int unsigned ref_count;
	int unsigned cycle = 0;
	int          seed = 62;

	// reference copy of the random words
	logic [31:0] ref_addr [NUM_WORDS];
	logic [31:0] ref_data [NUM_WORDS];

	// memory side of the shared data bus
	assign dq_to_dut = mem_oe ? mem_dq : 16'hzzzz;

	sdram_wb_slave dut_i (
		.clk           (clk),
		.rst           (rst),
		.wb_stb_i      (wb_stb),
		.wb_cyc_i      (wb_cyc),
		.wb_we_i       (wb_we),
		.wb_adr_i      (wb_adr),
		.wb_dat_i      (wb_dat_w),
		.wb_ack_o      (wb_ack),
		.wb_dat_o      (wb_dat_r),
		.sdram_cmd_o   (sdram_cmd),
		.sdram_dq_o    (ctrl_dq),
		.sdram_dq_oe_o (ctrl_oe),
		.sdram_dq_i    (dq_to_dut)
	);

	sdram_model mem_i (
		.clk         (clk),
		.cmd_i       (sdram_cmd),
		.dq_i        (ctrl_dq),
		.dq_oe_i     (ctrl_oe),
		.dq_o        (mem_dq),
		.dq_oe_o     (mem_oe),
		.fault_o     (mem_fault),
		.act_count_o (act_count),
		.ref_count_o (ref_count)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	task abort_run(input string reason);
		$display("Simulation failed");
		$fatal(1, "%s", reason);
	endtask

	task automatic compare_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
			abort_run("a checked value differed from the expected one");
		end
	endtask

	task automatic compare_status(input ctrl_status_t got, input ctrl_status_t exp);
		if (got !== exp) begin
			$display("Mismatch wb_dat_o[2:0] status: got 0x%0h expected 0x%0h", got, exp);
			abort_run("status flags differed from the expected ones");
		end
	endtask

	// model protocol errors end the run here
	always @(posedge clk) begin
		if (mem_fault === 1'b1)
			abort_run("the memory model saw an illegal command sequence");
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run("watchdog timeout, the tests ran past their cycle budget");
	end

	task automatic start_access(input logic we, input logic [31:0] adr,
		input logic [31:0] wdata);
		@(posedge clk);
		#DRIVE_DELAY;
		wb_stb = 1'b1;
		wb_cyc = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
	endtask

	// sampled one drive delay after the edge
	task automatic wait_ack();
		int n;
		n = 0;
		do begin
			@(posedge clk);
			#DRIVE_DELAY;
			n++;
		end while (wb_ack !== 1'b1 && n < ACK_BOUND);
		if (wb_ack !== 1'b1)
			abort_run("no acknowledge within the bus timeout");
	endtask

	// ack must drop at the first edge after the strobe
	task automatic release_bus();
		wb_stb = 1'b0;
		wb_cyc = 1'b0;
		wb_we = 1'b0;
		@(posedge clk);
		#DRIVE_DELAY;
		if (wb_ack !== 1'b0)
			abort_run("acknowledge stayed high after the strobe was released");
	endtask

	task automatic wb_write(input logic [31:0] adr, input logic [31:0] wdata,
		output logic [31:0] rsp);
		start_access(1'b1, adr, wdata);
		wait_ack();
		rsp = wb_dat_r;
		release_bus();
	endtask

	task automatic wb_read(input logic [31:0] adr, output logic [31:0] rsp);
		start_access(1'b0, adr, 32'h0);
		wait_ack();
		rsp = wb_dat_r;
		release_bus();
	endtask

	task automatic check_reset_state();
		compare_word("wb_ack_o", {31'h0, wb_ack}, 32'h0);
		compare_word("wb_dat_o", wb_dat_r, 32'h0);
		compare_word("sdram_cmd_o.cke", {31'h0, sdram_cmd.cke}, 32'h0);
		compare_word("sdram_cmd_o strobes", {28'h0, sdram_cmd.cs_n, sdram_cmd.ras_n,
			sdram_cmd.cas_n, sdram_cmd.we_n}, 32'hF);
		compare_word("sdram_dq_oe_o", {31'h0, ctrl_oe}, 32'h0);
	endtask

	// accesses during init get the error word
	task automatic test_not_ready();
		logic [31:0]  rsp;
		ctrl_status_t exp;
		wb_read(32'h0000_1234, rsp);
		compare_word("wb_dat_o read before ready", rsp, `SDRAM_ERR_WORD);
		wb_write(32'h0040_0010, 32'hA5A5_5A5A, rsp);
		compare_word("wb_dat_o write before ready", rsp, `SDRAM_ERR_WORD);
		wb_read(`SDRAM_STATUS_ADDR, rsp);
		exp = '{busy: 1'b1, ack: 1'b0, ready: 1'b0};
		compare_status(rsp[2:0], exp);
		compare_word("activate count before ready", act_count, 32'h0);
	endtask

	task automatic test_ready_poll();
		int unsigned  start;
		logic [31:0]  rsp;
		ctrl_status_t exp;
		start = cycle;
		do begin
			wb_read(`SDRAM_STATUS_ADDR, rsp);
			if (rsp[0] !== 1'b1 && cycle - start > POLL_MAX)
				abort_run("memory did not report ready within the init allowance");
		end while (rsp[0] !== 1'b1);
		compare_word("status upper bits", rsp & 32'hFFFF_FFF8, 32'h0);
		// idle, no access in flight
		exp = '{busy: 1'b0, ack: 1'b0, ready: 1'b1};
		compare_status(rsp[2:0], exp);
		compare_word("activate count after init", act_count, 32'h0);
	endtask

	task automatic test_write_read();
		logic [31:0] adr;
		logic [31:0] rsp;
		adr = 32'h0052_3456;
		wb_write(adr, 32'hCAFE_1234, rsp);
		wb_read(adr, rsp);
		compare_word("wb_dat_o write then read", rsp, 32'hCAFE_1234);
		// low half at the even device column
		compare_word("model even column", {16'h0, mem_i.peek(adr[23:22], adr[21:9],
			{adr[8:0], 1'b0})}, 32'h0000_1234);
		compare_word("model odd column", {16'h0, mem_i.peek(adr[23:22], adr[21:9],
			{adr[8:0], 1'b1})}, 32'h0000_CAFE);
	endtask

	task automatic test_random_words();
		logic [31:0] rsp;
		logic [31:0] adr;
		logic [31:0] rnd;
		bit          dup;
		int          i;
		int          j;
		int          idx;
		for (i = 0; i < NUM_WORDS; i++) begin
			// bank from the index so all four banks see traffic
			do begin
				rnd = $random(seed);
				adr = {8'h00, 2'(i), rnd[21:0]};
				dup = 1'b0;
				for (j = 0; j < i; j++) begin
					if (ref_addr[j] == adr)
						dup = 1'b1;
				end
			end while (dup || adr == `SDRAM_STATUS_ADDR);
			ref_addr[i] = adr;
			ref_data[i] = $random(seed);
			wb_write(adr, ref_data[i], rsp);
		end
		// stride 13 visits every word once in a new order
		for (i = 0; i < NUM_WORDS; i++) begin
			idx = (i * 13 + 7) % NUM_WORDS;
			wb_read(ref_addr[idx], rsp);
			compare_word("wb_dat_o random readback", rsp, ref_data[idx]);
		end
	endtask

	task automatic test_refresh_stream();
		int unsigned start;
		int unsigned ref_start;
		int          n;
		logic [31:0] rsp;
		start = cycle;
		ref_start = ref_count;
		n = 0;
		// margin lets the last due refresh get out
		while (cycle - start < REF_SPAN * `SDRAM_REFRESH_INTERVAL + 32 && n < STREAM_MAX) begin
			wb_read(ref_addr[n % NUM_WORDS], rsp);
			compare_word("wb_dat_o read stream", rsp, ref_data[n % NUM_WORDS]);
			n++;
		end
		if (cycle - start < REF_SPAN * `SDRAM_REFRESH_INTERVAL)
			abort_run("read stream ended before covering the refresh intervals");
		if (ref_count - ref_start < REF_SPAN)
			abort_run("fewer auto-refresh commands than refresh intervals");
	endtask

	task automatic test_held_strobe();
		logic [31:0] rsp;
		int unsigned acts;
		start_access(1'b0, ref_addr[3], 32'h0);
		wait_ack();
		compare_word("wb_dat_o held strobe", wb_dat_r, ref_data[3]);
		acts = act_count;
		repeat (8) begin
			@(posedge clk);
			#DRIVE_DELAY;
			compare_word("wb_ack_o strobe held", {31'h0, wb_ack}, 32'h1);
			compare_word("activate count strobe held", act_count, acts);
		end
		release_bus();
		compare_word("activate count after release", act_count, acts);
		// next access opens exactly one row
		wb_read(ref_addr[4], rsp);
		compare_word("wb_dat_o after held strobe", rsp, ref_data[4]);
		compare_word("activate count next access", act_count, acts + 1);
	endtask

	initial begin
		rst = 1'b1;
		wb_stb = 1'b0;
		wb_cyc = 1'b0;
		wb_we = 1'b0;
		wb_adr = 32'h0;
		wb_dat_w = 32'h0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		check_reset_state();
		rst = 1'b0;

		test_not_ready();
		test_ready_poll();
		test_write_read();
		test_random_words();
		test_refresh_stream();
		test_held_strobe();

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+logic
logic/sdram_pkg.sv
logic/wb_request_decode.sv
logic/sdram_cmd_sequencer.sv
logic/wb_response.sv
logic/sdram_wb_slave.sv
testbench/sdram_model.sv
testbench/tb_sdram_wb_slave.sv

// File: Bender.yml
package:
  name: sdram_wb_slave

export_include_dirs:
  - logic

sources:
  - files:
      - logic/sdram_pkg.sv
      - logic/wb_request_decode.sv
      - logic/sdram_cmd_sequencer.sv
      - logic/wb_response.sv
      - logic/sdram_wb_slave.sv
  - target: test
    files:
      - testbench/sdram_model.sv
      - testbench/tb_sdram_wb_slave.sv
